//--- filelist.f
logic/lsu_pkg.sv
logic/dmem_port.sv
logic/load_extend.sv
logic/wb_stage.sv
logic/lsu_wb_top.sv
verification/apb_mem_model.sv
verification/lsu_wb_asserts.sv
verification/tb_lsu_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_wb
SEED      ?= 67
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: build run clean

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_lsu_wb.sv
`timescale 1ns/1ps
// Testbench for the memory/writeback subsystem with directed APB load and store tests
module tb_lsu_wb
  import lsu_pkg::*;
();

  localparam int MAX_CYCLES = 2000;

  logic            clk;
  logic            rst;
  mem_stage_t      mem_stage;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  logic            stall;
  logic            regf_we;
  logic [4:0]      rd_addr;
  logic [XLEN-1:0] write_data;
  retire_t         retire;
  logic [3:0]      wait_states;

  int          errors = 0;
  int          tests = 0;
  int          cycles = 0;
  int          stall_cycles = 0;
  int          psel_cycles = 0;
  logic [63:0] order_count = '0;
  logic [31:0] pc_next;
  logic [7:0]  shadow [int];
  logic [4:0]  we_rd_q [$];
  logic [31:0] we_data_q [$];
  retire_t     retire_q [$];

  lsu_wb_top #(
    .ADDR_WIDTH(16)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .i_mem_stage (mem_stage),
    .i_apb       (apb_rsp),
    .o_apb       (apb_req),
    .o_stall     (stall),
    .o_regf_we   (regf_we),
    .o_rd_addr   (rd_addr),
    .o_write_data(write_data),
    .o_retire    (retire)
  );

  apb_mem_model u_mem (
    .clk          (clk),
    .rst          (rst),
    .i_wait_states(wait_states),
    .i_apb        (apb_req),
    .o_apb        (apb_rsp)
  );

  bind dmem_port lsu_wb_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .i_apb_req   (o_apb),
    .i_apb_rsp   (i_apb),
    .i_misaligned(o_misaligned),
    .i_done      (o_done),
    .i_stall     (o_stall)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  // Outputs sampled mid-cycle; retire order checked on every record
  always @(negedge clk) begin
    if (!rst) begin
      if (regf_we) begin
        we_rd_q.push_back(rd_addr);
        we_data_q.push_back(write_data);
      end
      if (retire.valid) begin
        if (retire.order !== order_count) begin
          errors++;
          $display("FAILED retire order: expected %0d, actual %0d", order_count, retire.order);
        end
        order_count = order_count + 64'd1;
        retire_q.push_back(retire);
      end
      if (stall) stall_cycles++;
      if (apb_req.psel) psel_cycles++;
    end
  end

  task automatic compare_word(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp_v, act_v);
    end
  endtask

  task automatic check_write(input string name, input int exp_n, input logic [4:0] exp_rd,
                             input logic [31:0] exp_v);
    if (we_data_q.size() != exp_n) begin
      errors++;
      $display("FAILED %s: expected %0d writes, actual %0d", name, exp_n, we_data_q.size());
    end else if (exp_n > 0) begin
      compare_word({name, " rd"}, 32'(exp_rd), 32'(we_rd_q[0]));
      compare_word(name, exp_v, we_data_q[0]);
    end
  endtask

  // Drive on the falling edge, holding the word while stalled
  task automatic issue(input mem_stage_t w);
    @(negedge clk);
    while (stall) @(negedge clk);
    mem_stage = w;
  endtask

  task automatic wait_retire(input int n);
    int waited;
    waited = 0;
    while (retire_q.size() < n && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (retire_q.size() < n) begin
      errors++;
      $display("Gave up waiting for %0d retirements, saw %0d", n, retire_q.size());
    end
  endtask

  task automatic run_op(input mem_stage_t w, output retire_t r);
    w.pc = pc_next;
    w.inst = $urandom;
    pc_next = pc_next + 32'd4;
    we_rd_q.delete();
    we_data_q.delete();
    retire_q.delete();
    issue(w);
    issue('0);
    wait_retire(1);
    r = (retire_q.size() > 0) ? retire_q[0] : '0;
    compare_word("retire pc", w.pc, r.pc);
    compare_word("retire inst", w.inst, r.inst);
    compare_word("retire mem_addr", w.func_out, r.mem_addr);
  endtask

  function automatic mem_stage_t make_mem(logic is_store, mem_funct3_e f3, logic [31:0] addr,
                                          logic [31:0] sdata, logic [4:0] rd);
    mem_stage_t w;
    w = '0;
    w.valid              = 1'b1;
    w.mem_ctrl.mem_read  = !is_store;
    w.mem_ctrl.mem_write = is_store;
    w.mem_ctrl.funct3    = f3;
    w.wb_sel             = is_store ? func_out : mem_rdata;
    w.regf_we            = !is_store;
    w.rd_addr            = is_store ? 5'd0 : rd;
    w.func_out           = addr;
    w.store_data         = sdata;
    return w;
  endfunction

  // Number of bytes an access of this width touches
  function automatic int access_bytes(mem_funct3_e f3);
    case (f3)
      lb, lbu: return 1;
      lh, lhu: return 2;
      default: return 4;
    endcase
  endfunction

  // Lanes covered by n bytes starting at lane off
  function automatic logic [3:0] byte_mask(int n, int off);
    logic [3:0] m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (b >= off && b < off + n) m[b] = 1'b1;
    end
    return m;
  endfunction

  // Byte model of memory, little endian
  task automatic store_shadow(input mem_funct3_e f3, input logic [31:0] addr,
                              input logic [31:0] data);
    int n;
    n = access_bytes(f3);
    for (int i = 0; i < n; i++) begin
      shadow[addr + 32'(i)] = data[8*i +: 8];
    end
  endtask

  function automatic logic [31:0] expect_load(mem_funct3_e f3, logic [31:0] addr);
    logic [31:0] v;
    case (f3)
      lb:      v = {{24{shadow[addr][7]}}, shadow[addr]};
      lbu:     v = {24'd0, shadow[addr]};
      lh:      v = {{16{shadow[addr + 1][7]}}, shadow[addr + 1], shadow[addr]};
      lhu:     v = {16'd0, shadow[addr + 1], shadow[addr]};
      default: v = {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    endcase
    return v;
  endfunction

  function automatic logic aligned(mem_funct3_e f3, logic [1:0] off);
    if (f3 == lh || f3 == lhu) return !off[0];
    if (f3 == lw) return off == 2'b00;
    return 1'b1;
  endfunction

  function automatic logic [31:0] rand_word_addr();
    return {20'd0, 10'($urandom_range(1023, 0)), 2'b00};
  endfunction

  task automatic test_alu_stream();
    mem_stage_t  w;
    logic [31:0] vals [10];
    int          stalls_before;
    tests++;
    we_rd_q.delete();
    we_data_q.delete();
    retire_q.delete();
    stalls_before = stall_cycles;
    for (int k = 0; k < 10; k++) begin
      w          = '0;
      w.valid    = 1'b1;
      w.wb_sel   = func_out;
      w.regf_we  = 1'b1;
      w.rd_addr  = 5'(k + 1);
      w.func_out = $urandom;
      w.pc       = pc_next;
      w.inst     = $urandom;
      pc_next    = pc_next + 32'd4;
      vals[k]    = w.func_out;
      issue(w);
    end
    issue('0);
    wait_retire(10);
    if (stall_cycles != stalls_before) begin
      errors++;
      $display("test_alu_stream: stall went high during back-to-back ALU ops");
    end
    compare_word("test_alu_stream write count", 32'd10, 32'(we_data_q.size()));
    for (int k = 0; k < 10 && k < we_data_q.size(); k++) begin
      compare_word($sformatf("test_alu_stream rd %0d", k), 32'(k + 1), 32'(we_rd_q[k]));
      compare_word($sformatf("test_alu_stream data %0d", k), vals[k], we_data_q[k]);
    end
    for (int k = 1; k < retire_q.size(); k++) begin
      compare_word("test_alu_stream order step", 32'(retire_q[k-1].order + 64'd1),
                   32'(retire_q[k].order));
    end
  endtask

  task automatic test_store_load_widths();
    mem_funct3_e widths [5] = '{lb, lbu, lh, lhu, lw};
    logic [31:0] base;
    logic [31:0] addr;
    logic [31:0] data;
    retire_t     r;
    tests++;
    base = rand_word_addr();
    data = $urandom;
    run_op(make_mem(1'b1, sw, base, data, 5'd0), r);
    store_shadow(sw, base, data);
    check_write("test_store_load_widths sw", 0, 5'd0, 32'd0);
    compare_word("test_store_load_widths wmask", 32'hf, 32'(r.mem_wmask));
    foreach (widths[i]) begin
      for (int off = 0; off < 4; off++) begin
        addr = base + 32'(off);
        if (aligned(widths[i], addr[1:0])) begin
          run_op(make_mem(1'b0, widths[i], addr, 32'd0, 5'd7), r);
          check_write($sformatf("test_store_load_widths %s+%0d", widths[i].name(), off), 1,
                      5'd7, expect_load(widths[i], addr));
          compare_word($sformatf("test_store_load_widths rmask %s+%0d", widths[i].name(), off),
                       32'(byte_mask(access_bytes(widths[i]), off)), 32'(r.mem_rmask));
        end
      end
    end
  endtask

  task automatic test_partial_stores();
    mem_funct3_e f3;
    logic [31:0] base;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    retire_t     r;
    tests++;
    base = rand_word_addr();
    data = $urandom;
    run_op(make_mem(1'b1, sw, base, data, 5'd0), r);
    store_shadow(sw, base, data);
    for (int off = 0; off < 4; off++) begin
      for (int h = 0; h < 2; h++) begin
        f3 = (h == 1) ? sh : sb;
        addr = base + 32'(off);
        if (aligned(f3, addr[1:0])) begin
          data = $urandom;
          mask = byte_mask(h + 1, off);
          run_op(make_mem(1'b1, f3, addr, data, 5'd0), r);
          store_shadow(f3, addr, data);
          compare_word($sformatf("test_partial_stores wmask %s+%0d", f3.name(), off),
                       32'(mask), 32'(r.mem_wmask));
          run_op(make_mem(1'b0, lw, base, 32'd0, 5'd3), r);
          check_write($sformatf("test_partial_stores %s+%0d", f3.name(), off), 1, 5'd3,
                      expect_load(lw, base));
        end
      end
    end
  endtask

  task automatic test_wait_states();
    logic [3:0]  ws_list [3] = '{4'd0, 4'd1, 4'd3};
    logic [31:0] addr;
    logic [31:0] data;
    int          stalls_before;
    retire_t     r;
    tests++;
    foreach (ws_list[i]) begin
      wait_states = ws_list[i];
      addr = rand_word_addr();
      data = $urandom;
      run_op(make_mem(1'b1, sw, addr, data, 5'd0), r);
      store_shadow(sw, addr, data);
      stalls_before = stall_cycles;
      run_op(make_mem(1'b0, lw, addr, 32'd0, 5'd12), r);
      // SETUP plus one stalled ACCESS per wait state
      compare_word($sformatf("test_wait_states stall cycles ws=%0d", ws_list[i]),
                   32'(ws_list[i]) + 32'd1, 32'(stall_cycles - stalls_before));
      check_write($sformatf("test_wait_states ws=%0d", ws_list[i]), 1, 5'd12,
                  expect_load(lw, addr));
    end
    wait_states = 4'd0;
  endtask

  task automatic test_misaligned();
    mem_funct3_e kinds [5] = '{lh, lh, lw, lw, lw};
    int          offs [5] = '{1, 3, 1, 2, 3};
    logic [31:0] base;
    logic [31:0] data;
    int          psel_before;
    retire_t     r;
    tests++;
    base = rand_word_addr();
    data = $urandom;
    run_op(make_mem(1'b1, sw, base, data, 5'd0), r);
    store_shadow(sw, base, data);
    foreach (kinds[i]) begin
      psel_before = psel_cycles;
      run_op(make_mem(1'b0, kinds[i], base + 32'(offs[i]), 32'd0, 5'd9), r);
      check_write("test_misaligned write", 0, 5'd0, 32'd0);
      compare_word("test_misaligned psel cycles", 32'd0, 32'(psel_cycles - psel_before));
      compare_word("test_misaligned trap", 32'd1, 32'(r.trap));
    end
    run_op(make_mem(1'b0, lw, base, 32'd0, 5'd9), r);
    check_write("test_misaligned aligned lw", 1, 5'd9, expect_load(lw, base));
    compare_word("test_misaligned aligned trap", 32'd0, 32'(r.trap));
  endtask

  initial begin
    void'($urandom(67));
    rst         = 1'b1;
    mem_stage   = '0;
    wait_states = 4'd0;
    pc_next     = 32'h0000_0100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (stall || regf_we || apb_req.psel || apb_req.penable || retire.valid) begin
      errors++;
      $display("Outputs not idle after reset");
    end
    test_alu_stream();
    test_store_load_widths();
    test_partial_stores();
    test_wait_states();
    test_misaligned();
    $display("Summary: %0d errors in %0d tests", errors, tests);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_lsu_wb

//--- verification/lsu_wb_asserts.sv
`timescale 1ns/1ps
// APB protocol and completion assertions for the data memory port
module lsu_wb_asserts
  import lsu_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input apb_req_t i_apb_req,
  input apb_rsp_t i_apb_rsp,
  input logic     i_misaligned,
  input logic     i_done,
  input logic     i_stall
);

  // SETUP always leads into ACCESS
  a_setup_access: assert property (@(posedge clk) disable iff (rst)
    i_apb_req.psel && !i_apb_req.penable |=> i_apb_req.psel && i_apb_req.penable)
    else $error("APB SETUP cycle not followed by ACCESS");

  // Request held steady while the slave inserts wait states
  a_stable_wait: assert property (@(posedge clk) disable iff (rst)
    i_apb_req.psel && i_apb_req.penable && !i_apb_rsp.pready |=>
      $stable(i_apb_req.paddr) && $stable(i_apb_req.pwrite) &&
      $stable(i_apb_req.pwdata) && $stable(i_apb_req.pstrb))
    else $error("APB request changed during a wait state");

  a_no_sel_misaligned: assert property (@(posedge clk) disable iff (rst)
    i_misaligned |-> !i_apb_req.psel)
    else $error("APB select raised for a misaligned access");

  // Completion and stall are exclusive
  a_done_no_stall: assert property (@(posedge clk) disable iff (rst)
    i_done |-> !i_stall)
    else $error("Completion signalled while stalled");

endmodule : lsu_wb_asserts

//--- verification/apb_mem_model.sv
`timescale 1ns/1ps
// APB slave memory with byte strobes and a settable wait-state count
module apb_mem_model
  import lsu_pkg::*;
#(
  parameter int DEPTH_WORDS = 1024
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] i_wait_states,
  input  apb_req_t   i_apb,
  output apb_rsp_t   o_apb
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  logic [XLEN-1:0]  mem [DEPTH_WORDS];
  logic [3:0]       wait_cnt;
  logic             access;
  logic [IDX_W-1:0] idx;

  assign idx    = i_apb.paddr[IDX_W+1:2];
  assign access = i_apb.psel && i_apb.penable;

  always_comb begin
    o_apb.pready = access && (wait_cnt >= i_wait_states);
    o_apb.prdata = mem[idx];
  end

  // Fill pattern taken from the full word index
  initial begin
    for (int i = 0; i < DEPTH_WORDS; i++) begin
      mem[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
    end
  end

  // Wait cycles counted inside ACCESS only
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wait_cnt <= 4'd0;
    end else if (access && !o_apb.pready) begin
      wait_cnt <= wait_cnt + 4'd1;
    end else begin
      wait_cnt <= 4'd0;
    end
  end

  always @(posedge clk) begin
    if (access && o_apb.pready && i_apb.pwrite) begin
      for (int b = 0; b < 4; b++) begin
        if (i_apb.pstrb[b]) mem[idx][8*b +: 8] <= i_apb.pwdata[8*b +: 8];
      end
    end
  end

endmodule : apb_mem_model

//--- logic/lsu_wb_top.sv
`timescale 1ns/1ps
// Memory and writeback top: APB data port, load formatter and writeback
module lsu_wb_top
  import lsu_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  mem_stage_t      i_mem_stage,
  input  apb_rsp_t        i_apb,
  output apb_req_t        o_apb,
  output logic            o_stall,
  output logic            o_regf_we,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_write_data,
  output retire_t         o_retire
);

  mem_stage_t      hold;
  logic            done;
  logic            misaligned;
  logic [XLEN-1:0] rdata_raw;
  logic [XLEN-1:0] load_data;

  dmem_port #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_dmem_port (
    .clk         (clk),
    .rst         (rst),
    .i_mem_stage (i_mem_stage),
    .i_apb       (i_apb),
    .o_apb       (o_apb),
    .o_hold      (hold),
    .o_done      (done),
    .o_rdata_raw (rdata_raw),
    .o_misaligned(misaligned),
    .o_stall     (o_stall)
  );

  load_extend u_load_extend (
    .i_funct3   (hold.mem_ctrl.funct3),
    .i_addr_lo  (hold.func_out[1:0]),
    .i_rdata_raw(rdata_raw),
    .o_load_data(load_data)
  );

  // Store strobes double as the retirement write mask
  wb_stage u_wb_stage (
    .clk         (clk),
    .rst         (rst),
    .i_hold      (hold),
    .i_done      (done),
    .i_misaligned(misaligned),
    .i_load_data (load_data),
    .i_rdata_raw (rdata_raw),
    .i_wmask     (o_apb.pstrb),
    .o_regf_we   (o_regf_we),
    .o_rd_addr   (o_rd_addr),
    .o_write_data(o_write_data),
    .o_retire    (o_retire)
  );

endmodule : lsu_wb_top

//--- logic/wb_stage.sv
`timescale 1ns/1ps
// Writeback stage: register write selection and retirement record latch
module wb_stage
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  mem_stage_t      i_hold,
  input  logic            i_done,
  input  logic            i_misaligned,
  input  logic [XLEN-1:0] i_load_data,
  input  logic [XLEN-1:0] i_rdata_raw,
  input  logic [3:0]      i_wmask,
  output logic            o_regf_we,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_write_data,
  output retire_t         o_retire
);

  logic [63:0]     order_q;
  logic            is_load;
  logic            is_mem;
  logic [1:0]      addr_lo;
  logic [3:0]      rmask;
  logic [XLEN-1:0] wdata_lane;

  assign addr_lo = i_hold.func_out[1:0];
  assign is_load = i_hold.mem_ctrl.mem_read && !i_misaligned;
  assign is_mem  = i_hold.mem_ctrl.mem_read || i_hold.mem_ctrl.mem_write;

  // Register file write port
  assign o_regf_we    = i_done && i_hold.regf_we && !i_misaligned;
  assign o_rd_addr    = i_hold.rd_addr;
  assign o_write_data = (i_hold.wb_sel == func_out) ? i_hold.func_out : i_load_data;

  // Bytes touched by a load
  always_comb begin
    rmask = 4'b0000;
    if (is_load) begin
      case (i_hold.mem_ctrl.funct3)
        lb, lbu: rmask = 4'b0001 << addr_lo;
        lh, lhu: rmask = 4'b0011 << addr_lo;
        default: rmask = 4'b1111;
      endcase
    end
  end

  // Store data as it sits on the bus lanes
  assign wdata_lane = (|i_wmask) ? (i_hold.store_data << {addr_lo, 3'b000}) : '0;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      o_retire <= '0;
      order_q  <= '0;
    end else begin
      o_retire.valid <= i_done;
      if (i_done) begin
        order_q            <= order_q + 64'd1;
        o_retire.order     <= order_q;
        o_retire.inst      <= i_hold.inst;
        o_retire.pc        <= i_hold.pc;
        o_retire.rd_addr   <= o_regf_we ? i_hold.rd_addr : 5'd0;
        o_retire.rd_wdata  <= o_regf_we ? o_write_data : '0;
        o_retire.mem_addr  <= is_mem ? i_hold.func_out : '0;
        o_retire.mem_rmask <= rmask;
        o_retire.mem_wmask <= i_wmask;
        o_retire.mem_rdata <= is_load ? i_rdata_raw : '0;
        o_retire.mem_wdata <= wdata_lane;
        o_retire.trap      <= i_misaligned;
      end
    end
  end

endmodule : wb_stage

//--- logic/load_extend.sv
`timescale 1ns/1ps
// Load formatter: lane select and sign or zero extension of bus read data
module load_extend
  import lsu_pkg::*;
(
  input  mem_funct3_e     i_funct3,
  input  logic [1:0]      i_addr_lo,
  input  logic [XLEN-1:0] i_rdata_raw,
  output logic [XLEN-1:0] o_load_data
);

  load_word_u  raw;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  assign raw.word = i_rdata_raw;

  // Byte lane from both address bits, half-word lane from bit 1 only
  assign lane_byte = raw.bytes[i_addr_lo];
  assign lane_half = raw.halves[i_addr_lo[1]];

  always_comb begin
    case (i_funct3)
      lb:      o_load_data = {{24{lane_byte[7]}}, lane_byte};
      lbu:     o_load_data = {24'd0, lane_byte};
      lh:      o_load_data = {{16{lane_half[15]}}, lane_half};
      lhu:     o_load_data = {16'd0, lane_half};
      // Whole word for lw and the unused codes
      default: o_load_data = raw.word;
    endcase
  end

endmodule : load_extend

//--- logic/dmem_port.sv
`timescale 1ns/1ps
// Data memory port: holds the current instruction and runs its APB transfer
module dmem_port
  import lsu_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  mem_stage_t      i_mem_stage,
  input  apb_rsp_t        i_apb,
  output apb_req_t        o_apb,
  output mem_stage_t      o_hold,
  output logic            o_done,
  output logic [XLEN-1:0] o_rdata_raw,
  output logic            o_misaligned,
  output logic            o_stall
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

  state_e     state_q, state_d;
  logic       hold_valid;
  mem_stage_t hold_q;
  logic       start;
  logic       bus_op;
  logic [1:0] addr_lo;
  logic [3:0] lane_mask;

  // Half-words need even addresses, words need a multiple of four
  function automatic logic is_misaligned(mem_funct3_e f3, logic [1:0] lo);
    logic bad;
    case (f3)
      lh, lhu: bad = lo[0];
      lw:      bad = |lo;
      default: bad = 1'b0;
    endcase
    return bad;
  endfunction

  function automatic logic is_mem(mem_ctrl_t ctrl);
    return ctrl.mem_read | ctrl.mem_write;
  endfunction

  // Stalled through SETUP and every ACCESS cycle that is not the last
  assign o_stall = (state_q == SETUP) || (state_q == ACCESS && !i_apb.pready);

  assign start = i_mem_stage.valid && !o_stall && is_mem(i_mem_stage.mem_ctrl) &&
                 !is_misaligned(i_mem_stage.mem_ctrl.funct3, i_mem_stage.func_out[1:0]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  if (i_apb.pready) state_d = start ? SETUP : IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q    <= IDLE;
      hold_valid <= 1'b0;
    end else begin
      state_q <= state_d;
      if (!o_stall) hold_valid <= i_mem_stage.valid;
    end
  end

  // Instruction payload, loaded whenever the stage can advance
  always_ff @(posedge clk) begin
    if (!o_stall) hold_q <= i_mem_stage;
  end

  always_comb begin
    o_hold       = hold_q;
    o_hold.valid = hold_valid;
  end

  assign addr_lo      = hold_q.func_out[1:0];
  assign o_misaligned = hold_valid && is_mem(hold_q.mem_ctrl) &&
                        is_misaligned(hold_q.mem_ctrl.funct3, addr_lo);
  assign bus_op       = hold_valid && is_mem(hold_q.mem_ctrl) && !o_misaligned;

  // ALU and trapped ops finish at once, bus ops on the pready edge
  assign o_done      = hold_valid && (!bus_op || (state_q == ACCESS && i_apb.pready));
  assign o_rdata_raw = i_apb.prdata;

  // Byte strobes for the store width at its lane
  always_comb begin
    case (hold_q.mem_ctrl.funct3)
      sb:      lane_mask = 4'b0001 << addr_lo;
      sh:      lane_mask = 4'b0011 << addr_lo;
      sw:      lane_mask = 4'b1111;
      default: lane_mask = 4'b0000;
    endcase
  end

  always_comb begin
    o_apb.psel    = (state_q != IDLE);
    o_apb.penable = (state_q == ACCESS);
    o_apb.pwrite  = hold_q.mem_ctrl.mem_write;
    o_apb.paddr   = APB_ADDR_MAX'(hold_q.func_out[ADDR_WIDTH-1:0]);
    // Store data moved up to its byte lane
    o_apb.pwdata  = hold_q.store_data << {addr_lo, 3'b000};
    o_apb.pstrb   = (bus_op && hold_q.mem_ctrl.mem_write) ? lane_mask : 4'b0000;
  end

endmodule : dmem_port

//--- logic/lsu_pkg.sv
// Memory/writeback package: shared types, load-word union and APB structs
package lsu_pkg;

  // Data path width
  localparam int XLEN = 32;

  // paddr field width; ADDR_WIDTH of the port never exceeds this
  localparam int APB_ADDR_MAX = 32;

  // Access width code, funct3 of the load and store opcodes
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } mem_funct3_e;

  // Stores share the code points of the signed loads
  localparam mem_funct3_e sb = lb;
  localparam mem_funct3_e sh = lh;
  localparam mem_funct3_e sw = lw;

  // Writeback source select
  typedef enum logic {
    func_out  = 1'b0,
    mem_rdata = 1'b1
  } wb_sel_e;

  typedef struct packed {
    logic        mem_read;
    logic        mem_write;
    mem_funct3_e funct3;
  } mem_ctrl_t;

  // Stage word from the memory stage
  typedef struct packed {
    logic            valid;
    mem_ctrl_t       mem_ctrl;
    wb_sel_e         wb_sel;
    logic            regf_we;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] func_out;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } mem_stage_t;

  // Bus read word, seen as bytes or as half-words
  typedef union packed {
    logic [XLEN-1:0]  word;
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } load_word_u;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [APB_ADDR_MAX-1:0] paddr;
    logic [XLEN-1:0]         pwdata;
    logic [3:0]              pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
  } apb_rsp_t;

  // Retirement record, RVFI style
  typedef struct packed {
    logic            valid;
    logic [63:0]     order;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] mem_addr;
    logic [3:0]      mem_rmask;
    logic [3:0]      mem_wmask;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] mem_wdata;
    logic            trap;
  } retire_t;

endpackage : lsu_pkg
